/* node_defs.svh */
`ifndef NODE_DEFS_SVH
`define NODE_DEFS_SVH

// ----------------------------------------------------------
// Serial link timing and framing
// ----------------------------------------------------------
`define NODE_BIT_CYCLES  4      // HCLK cycles per serial bit
`define NODE_FRAME_BITS  42     // start + 8 addr + 32 data + stop
`define NODE_ADDRESS     8'hab  // Own node address

// ----------------------------------------------------------
// Receive buffer and register map
// ----------------------------------------------------------
`define NODE_FIFO_DEPTH  8
`define NODE_REG_DATA    2'd0   // HADDR[3:2] offset that pops the FIFO
`define NODE_REG_COUNT   2'd1   // HADDR[3:2] offset of the fill count

`endif

/* node_pkg.sv */
package node_pkg;

	// Frame address field taken from HADDR[11:4] on transmit
	typedef logic [7:0] node_addr_t;

	// Payload word of a frame
	typedef logic [31:0] node_word_t;

	// Receive FIFO fill level from 0 to 8
	typedef logic [3:0] fifo_count_t;

	// AHB slave control
	typedef enum logic [2:0] {
		IDLE,
		WRITE_LATCH,
		WRITE_WAIT,
		READ_POP,
		READ_DONE
	} slave_state_t;

endpackage

/* node_ifs.sv */
`timescale 1ns/1ns

// ----------------------------------------------------------
// Slave FSM to frame transmitter
// ----------------------------------------------------------
interface tx_link_if import node_pkg::*; ();
	logic       tx_valid;
	node_addr_t tx_addr;
	node_word_t tx_data;
	logic       tx_ready;
	logic       tx_done;  // One cycle at end of ack window
	logic       tx_ok;    // Qualified by tx_done

	modport source (output tx_valid, tx_addr, tx_data, input tx_ready, tx_done, tx_ok);
	modport target (input tx_valid, tx_addr, tx_data, output tx_ready, tx_done, tx_ok);
endinterface

// ----------------------------------------------------------
// Receive FIFO with push side from frame_rx and pop side from FSM
// ----------------------------------------------------------
interface fifo_if import node_pkg::*; ();
	logic        push_valid;
	node_word_t  push_data;
	logic        push_ready;
	logic        pop;
	node_word_t  pop_data;   // Head word
	fifo_count_t count;
	logic        empty;

	modport push (output push_valid, push_data, input push_ready);
	modport store (
		input  push_valid, push_data, pop,
		output push_ready, pop_data, count, empty
	);
	modport pop_side (output pop, input pop_data, count, empty);
endinterface

/* bit_timer.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module bit_timer (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic restart,
	input  logic run,
	output logic mid_tick,
	output logic bit_tick
);

	localparam int CW  = $clog2(`NODE_BIT_CYCLES);
	localparam int MID = `NODE_BIT_CYCLES / 2 - 1;

	logic [CW-1:0] cnt;

	assign mid_tick = run & (cnt == CW'(MID));
	assign bit_tick = run & (cnt == CW'(`NODE_BIT_CYCLES - 1));

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || restart)
			cnt <= '0;
		else if (run)
			cnt <= bit_tick ? '0 : cnt + 1'b1;  // Wraps each bit
	end

endmodule

/* frame_tx.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module frame_tx (
	input  logic       HCLK,
	input  logic       HRESETn,
	tx_link_if.target  link,
	input  logic       DIN,
	output logic       DOUT,
	output logic       busy
);

	localparam int FB = `NODE_FRAME_BITS;

	logic [FB-1:0]              shreg;
	logic [$clog2(FB+1)-1:0]    bit_cnt;  // FB means ack window
	logic                       start;
	logic                       in_ack;
	logic                       ack_low;
	logic                       mid_tick;
	logic                       bit_tick;

	assign link.tx_ready = ~busy;
	assign start  = link.tx_valid & link.tx_ready;
	assign in_ack = (bit_cnt == FB);
	assign DOUT   = shreg[FB-1];  // Ones shift in behind the frame

	bit_timer u_timer (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.restart  (start),
		.run      (busy),
		.mid_tick (mid_tick),
		.bit_tick (bit_tick)
	);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			busy         <= 1'b0;
			shreg        <= '1;
			bit_cnt      <= '0;
			ack_low      <= 1'b0;
			link.tx_done <= 1'b0;
			link.tx_ok   <= 1'b0;
		end
		else
		begin
			link.tx_done <= 1'b0;
			if (start)
			begin
				busy    <= 1'b1;
				shreg   <= {1'b0, link.tx_addr, link.tx_data, 1'b1};
				bit_cnt <= '0;
				ack_low <= 1'b0;
			end
			else if (busy)
			begin
				if (in_ack && mid_tick)
					ack_low <= ~DIN;  // Far node pulls low to ack
				if (bit_tick && in_ack)
				begin
					busy         <= 1'b0;
					link.tx_done <= 1'b1;
					link.tx_ok   <= ack_low;
				end
				else if (bit_tick)
				begin
					shreg   <= {shreg[FB-2:0], 1'b1};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* frame_rx.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module frame_rx import node_pkg::*; (
	input  logic  HCLK,
	input  logic  HRESETn,
	input  logic  DIN,
	input  logic  hold,
	fifo_if.push  fifo
);

	localparam int FB = `NODE_FRAME_BITS;

	// Holds all bits but the stop bit, which is checked straight off DIN
	logic [FB-2:0]            shreg;
	logic [$clog2(FB+1)-1:0]  bit_cnt;
	logic                     active;
	logic                     din_q;
	logic                     start;
	logic                     last_bit;
	logic                     frame_ok;
	logic                     mid_tick;
	node_addr_t               rx_addr;

	assign start    = ~active & ~hold & din_q & ~DIN;
	assign last_bit = (bit_cnt == FB - 1);
	assign rx_addr  = shreg[FB-3 -: 8];
	assign frame_ok = ~shreg[FB-2] & DIN & (rx_addr == `NODE_ADDRESS);

	bit_timer u_timer (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.restart  (start),
		.run      (active),
		.mid_tick (mid_tick),
		.bit_tick ()
	);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			active          <= 1'b0;
			din_q           <= 1'b1;
			bit_cnt         <= '0;
			fifo.push_valid <= 1'b0;
		end
		else
		begin
			din_q           <= DIN;
			fifo.push_valid <= 1'b0;  // Dropped if FIFO not ready
			if (start)
			begin
				active  <= 1'b1;
				bit_cnt <= '0;
			end
			else if (active && mid_tick)
			begin
				if (last_bit)
				begin
					active          <= 1'b0;  // Free again mid stop bit
					fifo.push_valid <= frame_ok;
				end
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (active && mid_tick)
		begin
			if (last_bit)
				fifo.push_data <= shreg[31:0];
			else
				shreg <= {shreg[FB-3:0], DIN};
		end
	end

endmodule

/* rx_fifo.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module rx_fifo import node_pkg::*; (
	input  logic   HCLK,
	input  logic   HRESETn,
	fifo_if.store  fifo
);

	localparam int PW = $clog2(`NODE_FIFO_DEPTH);

	node_word_t  mem [`NODE_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	fifo_count_t cnt;
	logic        do_push;
	logic        do_pop;

	assign fifo.push_ready = (cnt != fifo_count_t'(`NODE_FIFO_DEPTH));
	assign fifo.empty      = (cnt == '0);
	assign fifo.count      = cnt;
	assign fifo.pop_data   = mem[rd_ptr];

	assign do_push = fifo.push_valid & fifo.push_ready;
	assign do_pop  = fifo.pop & ~fifo.empty;

	always_ff @(posedge HCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= fifo.push_data;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			cnt <= cnt + do_push - do_pop;  // Both at once leaves it unchanged
		end
	end

endmodule

/* ahb_slave_fsm.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module ahb_slave_fsm import node_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HREADY,
	input  node_word_t  HWDATA,
	output logic        HREADYOUT,
	output node_word_t  HRDATA,
	tx_link_if.source   link,
	fifo_if.pop_side    fifo,
	output logic        tx_success,
	output logic        tx_fail
);

	slave_state_t state;
	node_addr_t   addr_q;
	node_word_t   wdata_q;
	node_word_t   rd_word;
	logic [1:0]   reg_q;    // Word offset of the read
	logic         accept;

	// Only word-sized NONSEQ/SEQ transfers get wait states
	assign accept = HSEL & HREADY & HTRANS[1] & (HSIZE == 3'b010);

	assign link.tx_addr = addr_q;
	assign link.tx_data = wdata_q;
	assign tx_success   = link.tx_done & link.tx_ok;
	assign tx_fail      = link.tx_done & ~link.tx_ok;

	assign fifo.pop = (state == READ_POP) && (reg_q == `NODE_REG_DATA) && !fifo.empty;

	always_comb
	begin
		case (reg_q)
			`NODE_REG_DATA:  rd_word = fifo.empty ? '0 : fifo.pop_data;
			`NODE_REG_COUNT: rd_word = node_word_t'(fifo.count);
			default:         rd_word = '0;
		endcase
	end

	// ----------------------------------------------------------
	// Control
	// ----------------------------------------------------------
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state         <= IDLE;
			HREADYOUT     <= 1'b1;
			HRDATA        <= '0;
			link.tx_valid <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (accept)
					begin
						HREADYOUT <= 1'b0;
						if (HWRITE)
							state <= WRITE_LATCH;
						else
							state <= READ_POP;
					end
				WRITE_LATCH:
				begin
					link.tx_valid <= 1'b1;
					state         <= WRITE_WAIT;
				end
				WRITE_WAIT:
				begin
					if (link.tx_valid && link.tx_ready)
						link.tx_valid <= 1'b0;
					if (link.tx_done)
					begin
						HREADYOUT <= 1'b1;
						state     <= IDLE;
					end
				end
				READ_POP:
				begin
					HRDATA <= rd_word;
					state  <= READ_DONE;
				end
				READ_DONE:
				begin
					HREADYOUT <= 1'b1;
					state     <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address phase and write data
	always_ff @(posedge HCLK)
	begin
		if (state == IDLE && accept)
		begin
			addr_q <= HADDR[11:4];
			reg_q  <= HADDR[3:2];
		end
		if (state == WRITE_LATCH)
			wdata_q <= HWDATA;
	end

endmodule

/* ahb_serial_node.sv */
`timescale 1ns/1ns

module ahb_serial_node (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic        HREADYOUT,
	output logic [31:0] HRDATA,
	input  logic        DIN,
	output logic        DOUT,
	output logic        tx_success,
	output logic        tx_fail,
	output logic        fifo_empty
);

	logic tx_busy;  // Receiver ignores DIN while set

	tx_link_if u_link ();
	fifo_if    u_fifo ();

	assign fifo_empty = u_fifo.empty;

	ahb_slave_fsm u_fsm (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.HSEL       (HSEL),
		.HADDR      (HADDR),
		.HWRITE     (HWRITE),
		.HSIZE      (HSIZE),
		.HTRANS     (HTRANS),
		.HREADY     (HREADY),
		.HWDATA     (HWDATA),
		.HREADYOUT  (HREADYOUT),
		.HRDATA     (HRDATA),
		.link       (u_link.source),
		.fifo       (u_fifo.pop_side),
		.tx_success (tx_success),
		.tx_fail    (tx_fail)
	);

	frame_tx u_tx (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.link    (u_link.target),
		.DIN     (DIN),
		.DOUT    (DOUT),
		.busy    (tx_busy)
	);

	frame_rx u_rx (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.DIN     (DIN),
		.hold    (tx_busy),
		.fifo    (u_fifo.push)
	);

	rx_fifo u_fifo_mem (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.fifo    (u_fifo.store)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic HCLK,
	output logic HRESETn
);

	initial
	begin
		HCLK = 1'b0;
		forever #20 HCLK = ~HCLK;  // 40 ns period
	end

	initial
	begin
		HRESETn = 1'b0;
		repeat (8) @(posedge HCLK);
		@(negedge HCLK);
		HRESETn = 1'b1;
	end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module tb_checker import node_pkg::*; (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	input  logic        HREADYOUT,
	input  logic [31:0] HRDATA,
	input  logic        DOUT,
	input  logic        tx_success,
	input  logic        tx_fail,
	input  logic        fifo_empty,
	input  logic        ack_plan,  // Far node acks the next write
	input  logic        rf_valid,  // A remote frame has just ended on DIN
	input  node_addr_t  rf_addr,
	input  node_word_t  rf_data,
	output int          err_count,
	output int          check_count
);

	localparam int FB = `NODE_FRAME_BITS;

	node_word_t  model_q [$];
	logic [39:0] exp_q [$];  // Address and data of each write
	int          writes;
	int          frames;

	task automatic compare(input string name, input logic [31:0] want, input logic [31:0] got);
		check_count++;
		if (want !== got)
		begin
			err_count++;
			$display("FAILED %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic report(input string text);
		err_count++;
		$display("%s", text);
	endtask

	task automatic watch_write(input node_addr_t addr, input logic ack);
		int n_ok;
		int n_fail;
		n_ok = 0;
		n_fail = 0;
		@(posedge HCLK);
		exp_q.push_back({addr, HWDATA});  // Data phase
		writes++;
		while (!HREADYOUT)
		begin
			@(posedge HCLK);
			n_ok += tx_success;
			n_fail += tx_fail;
		end
		compare("tx_success pulses", ack, n_ok);
		compare("tx_fail pulses", !ack, n_fail);
		compare("frames on DOUT", writes, frames);
	endtask

	task automatic watch_read(input logic [1:0] off);
		int waits;
		node_word_t want;
		waits = 0;
		@(posedge HCLK);
		while (!HREADYOUT)
		begin
			waits++;
			@(posedge HCLK);
		end
		compare("read wait states", 2, waits);
		if (off == `NODE_REG_COUNT)
			want = model_q.size();
		else if (off == `NODE_REG_DATA && model_q.size() > 0)
			want = model_q.pop_front();
		else
			want = '0;  // Empty FIFO or unused offset
		compare(off == `NODE_REG_COUNT ? "read count" : "read data", want, HRDATA);
	endtask

	task automatic watch_skip;
		@(posedge HCLK);
		compare("zero wait state", 1, HREADYOUT);
	endtask

	// ----------------------------------------------------------
	// AHB monitor
	// ----------------------------------------------------------
	initial
	begin
		err_count = 0;
		check_count = 0;
		writes = 0;
		frames = 0;
		@(posedge HCLK);
		while (!HRESETn)
			@(posedge HCLK);
		compare("reset HREADYOUT", 1, HREADYOUT);
		compare("reset DOUT", 1, DOUT);
		compare("reset tx_success", 0, tx_success);
		compare("reset tx_fail", 0, tx_fail);
		compare("reset fifo_empty", 1, fifo_empty);
		forever
		begin
			@(posedge HCLK);
			if (HSEL && HREADY && HREADYOUT)
			begin
				compare("fifo_empty", model_q.size() == 0, fifo_empty);
				if (HTRANS[1] && HSIZE == 3'b010 && HWRITE)
					watch_write(HADDR[11:4], ack_plan);
				else if (HTRANS[1] && HSIZE == 3'b010)
					watch_read(HADDR[3:2]);
				else
					watch_skip();
			end
		end
	end

	// ----------------------------------------------------------
	// DOUT frame decoder
	// ----------------------------------------------------------
	initial
	begin : dout_decoder
		logic [FB-1:0] bits;
		logic [39:0]   want;
		forever
		begin
			@(posedge HCLK);
			if (HRESETn && !DOUT)
			begin
				repeat (`NODE_BIT_CYCLES / 2 - 1) @(posedge HCLK);  // To mid bit
				for (int i = 0; i < FB; i++)
				begin
					if (i > 0)
						repeat (`NODE_BIT_CYCLES) @(posedge HCLK);
					bits = {bits[FB-2:0], DOUT};
				end
				frames++;
				if (bits[FB-1] !== 1'b0 || bits[0] !== 1'b1)
					report("Frame on DOUT has a bad start or stop bit");
				if (exp_q.size() == 0)
					report("Frame on DOUT without a write");
				else
				begin
					want = exp_q.pop_front();
					compare("dout address", want[39:32], bits[FB-2 -: 8]);
					compare("dout data", want[31:0], bits[32:1]);
				end
			end
		end
	end

	// Model FIFO drops foreign addresses and frames that find it full
	always @(posedge HCLK)
	begin
		if (rf_valid && rf_addr == `NODE_ADDRESS && model_q.size() < `NODE_FIFO_DEPTH)
			model_q.push_back(rf_data);
	end

endmodule

/* tb_top.sv */
`timescale 1ns/1ns
`include "node_defs.svh"

module tb_top import node_pkg::*; ();

	localparam int NUM_OPS     = 40;
	localparam int CYCLE_LIMIT = NUM_OPS * 250 + 500;

	logic        HCLK;
	logic        HRESETn;
	logic        hsel;
	logic [31:0] haddr;
	logic        hwrite;
	logic [2:0]  hsize;
	logic [1:0]  htrans;
	logic        hready;
	logic [31:0] hwdata;
	logic        hreadyout;
	logic [31:0] hrdata;
	logic        din;
	logic        dout;
	logic        tx_success;
	logic        tx_fail;
	logic        fifo_empty;
	logic        ack_plan;
	logic        rf_valid;
	node_addr_t  rf_addr;
	node_word_t  rf_data;
	int          err_count;
	int          check_count;
	int          cycles = 0;

	tb_clock_gen u_clk (.HCLK(HCLK), .HRESETn(HRESETn));

	ahb_serial_node DUT (
		.HCLK (HCLK), .HRESETn (HRESETn), .HSEL (hsel), .HADDR (haddr),
		.HWRITE (hwrite), .HSIZE (hsize), .HTRANS (htrans), .HREADY (hready),
		.HWDATA (hwdata), .HREADYOUT (hreadyout), .HRDATA (hrdata), .DIN (din),
		.DOUT (dout), .tx_success (tx_success), .tx_fail (tx_fail), .fifo_empty (fifo_empty)
	);

	tb_checker u_chk (
		.HCLK (HCLK), .HRESETn (HRESETn), .HSEL (hsel), .HADDR (haddr),
		.HWRITE (hwrite), .HSIZE (hsize), .HTRANS (htrans), .HREADY (hready),
		.HWDATA (hwdata), .HREADYOUT (hreadyout), .HRDATA (hrdata), .DOUT (dout),
		.tx_success (tx_success), .tx_fail (tx_fail), .fifo_empty (fifo_empty),
		.ack_plan (ack_plan), .rf_valid (rf_valid), .rf_addr (rf_addr), .rf_data (rf_data),
		.err_count (err_count), .check_count (check_count)
	);

	task automatic wait_ready;
		@(negedge HCLK);
		while (!hreadyout)
			@(negedge HCLK);
		repeat (2) @(negedge HCLK);
	endtask

	// Far node of a write acks by pulling DIN low in the ack period
	task automatic far_node(input logic ack);
		while (dout)
			@(negedge HCLK);
		repeat (`NODE_FRAME_BITS * `NODE_BIT_CYCLES) @(negedge HCLK);
		din = ~ack;
		repeat (`NODE_BIT_CYCLES / 2) @(negedge HCLK);
		din = 1'b1;
	endtask

	task automatic ahb_write(input logic [31:0] addr, input node_word_t data, input logic ack);
		@(negedge HCLK);
		hsel = 1'b1;
		haddr = addr;
		hwrite = 1'b1;
		hsize = 3'b010;
		htrans = 2'b10;
		ack_plan = ack;
		@(negedge HCLK);
		hsel = 1'b0;
		htrans = 2'b00;
		hwdata = data;
		far_node(ack);
		wait_ready();
	endtask

	task automatic ahb_read(input logic [1:0] off);
		@(negedge HCLK);
		hsel = 1'b1;
		haddr = (32'($urandom) & 32'hffff_fff0) | {28'd0, off, 2'b00};
		hwrite = 1'b0;
		hsize = 3'b010;
		htrans = 2'b10;
		@(negedge HCLK);
		hsel = 1'b0;
		htrans = 2'b00;
		wait_ready();
	endtask

	// Idle transfer, or a byte or half-word transfer
	task automatic odd_transfer;
		@(negedge HCLK);
		hsel = 1'b1;
		haddr = $urandom;
		hwrite = 1'($urandom % 2);
		if ($urandom % 2)
		begin
			htrans = 2'b00;
			hsize = 3'b010;
		end
		else
		begin
			htrans = 2'b10;
			hsize = 3'($urandom % 2);
		end
		@(negedge HCLK);
		hsel = 1'b0;
		htrans = 2'b00;
		hsize = 3'b010;
		hwdata = $urandom;
		repeat (2) @(negedge HCLK);
	endtask

	task automatic send_frame(input node_addr_t addr, input node_word_t data);
		logic [`NODE_FRAME_BITS-1:0] bits;
		bits = {1'b0, addr, data, 1'b1};
		@(negedge HCLK);
		for (int i = `NODE_FRAME_BITS - 1; i >= 0; i--)
		begin
			din = bits[i];  // MSB first
			repeat (`NODE_BIT_CYCLES) @(negedge HCLK);
		end
		repeat (`NODE_BIT_CYCLES) @(negedge HCLK);
		rf_addr = addr;
		rf_data = data;
		rf_valid = 1'b1;
		@(negedge HCLK);
		rf_valid = 1'b0;
		repeat (2) @(negedge HCLK);
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial
	begin
		int op;
		hsel = 1'b0;
		haddr = '0;
		hwrite = 1'b0;
		hsize = 3'b010;
		htrans = 2'b00;
		hready = 1'b1;
		hwdata = '0;
		din = 1'b1;  // Line idles high
		ack_plan = 1'b0;
		rf_valid = 1'b0;
		rf_addr = '0;
		rf_data = '0;
		void'($urandom(32'h9dbcb014));
		@(posedge HRESETn);
		repeat (2) @(negedge HCLK);
		for (int n = 0; n < NUM_OPS; n++)
		begin
			op = $urandom % 8;
			case (op)
				0, 1:    ahb_write($urandom & 32'hffff_fff0, $urandom, 1'($urandom % 2));
				2, 3, 4: send_frame(($urandom % 4 != 0) ? `NODE_ADDRESS : node_addr_t'($urandom),
					$urandom);
				5:       ahb_read(`NODE_REG_DATA);
				6:       ahb_read(`NODE_REG_COUNT);
				default: odd_transfer();
			endcase
		end
		while (!fifo_empty)
			ahb_read(`NODE_REG_DATA);
		ahb_read(`NODE_REG_COUNT);
		ahb_read(`NODE_REG_DATA);  // Reads back zero when empty
		repeat (4) @(negedge HCLK);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	always @(posedge HCLK)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, errors: %0d", check_count, err_count);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+.
node_pkg.sv
node_ifs.sv
bit_timer.sv
frame_tx.sv
frame_rx.sv
rx_fifo.sv
ahb_slave_fsm.sv
ahb_serial_node.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv
